// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= lsu_tb
FILELIST  ?= vlog.f
LOG       ?= sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/lsu_bus_ctrl.sv
// bus request, outstanding transaction counter and ready/busy generation

`default_nettype none

module lsu_bus_ctrl (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           data_req_ex_i,  // held until ready_ex edge
  input  wire logic                           data_gnt_i,
  input  wire logic                           data_rvalid_i,
  output logic                                data_req_o,
  output logic [lsu_mem_pkg::ADDR_W-1:0]      data_addr_o,
  output logic                                data_we_o,
  output logic [lsu_mem_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_mem_pkg::DATA_W-1:0]      data_wdata_o,
  output logic                                lsu_ready_ex_o,
  output logic                                lsu_ready_wb_o,
  output logic                                busy_o,
  lsu_store_if.consumer                       st,
  lsu_wb_if.update_src                        wb
);

  logic [lsu_mem_pkg::CNT_W-1:0] cnt_q;     // granted, not yet answered
  logic [lsu_mem_pkg::CNT_W-1:0] cnt_nxt;
  logic                          count_up;  // grant this cycle
  logic                          count_dn;  // response this cycle

  ////////////////////
  // request side
  ////////////////////

  // no new request once DEPTH transactions are in flight
  assign data_req_o = data_req_ex_i && (cnt_q < lsu_mem_pkg::DEPTH);

  // payload straight from the EX request, stable while it is held
  assign data_addr_o  = st.addr;
  assign data_we_o    = st.we;
  assign data_be_o    = st.be;
  assign data_wdata_o = st.wdata;

  assign count_up = data_req_o && data_gnt_i;
  assign count_dn = data_rvalid_i;  // in order, never with cnt_q == 0

  ////////////////////
  // ready and busy
  ////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB move in lock step once WB holds a transaction
  always_comb begin
    if (!data_req_ex_i)    lsu_ready_ex_o = 1'b1;
    else if (cnt_q == '0)  lsu_ready_ex_o = count_up;
    else if (cnt_q == 2'd1) lsu_ready_ex_o = count_up && data_rvalid_i;
    else                   lsu_ready_ex_o = data_rvalid_i;  // already granted, waits for WB
  end

  assign wb.update = lsu_ready_ex_o && data_req_ex_i;

  assign busy_o = (cnt_q != '0) || data_req_o;

  // outstanding counter
  always_comb begin
    case ({count_up, count_dn})
      2'b10:   cnt_nxt = cnt_q + 1'b1;
      2'b01:   cnt_nxt = cnt_q - 1'b1;
      default: cnt_nxt = cnt_q;  // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lsu_ifs.sv
// store request interface and writeback control interface, with modports

`default_nettype none

// request side of one transaction, built from the current execute request
interface lsu_store_if;

  logic [lsu_mem_pkg::ADDR_W-1:0] addr;   // full byte address
  logic                           we;     // 1 = store
  logic [lsu_mem_pkg::BE_W-1:0]   be;     // byte lanes touched
  logic [lsu_mem_pkg::DATA_W-1:0] wdata;  // already rotated into lanes

  modport producer (output addr, output we, output be, output wdata);
  modport consumer (input addr, input we, input be, input wdata);

endinterface

// control that follows a transaction from EX into the WB stage
interface lsu_wb_if;

  logic                          update;  // EX/WB control hand-over strobe
  logic [lsu_op_pkg::SIZE_W-1:0] size;    // access size of the EX request
  logic [lsu_op_pkg::OFS_W-1:0]  offset;  // addr[1:0] of the EX request
  logic [lsu_op_pkg::EXT_W-1:0]  ext;     // extension mode of the EX request
  logic                          we;      // store, no load result expected

  modport update_src (output update);
  modport offset_src (output offset);

  // WB side picks everything up
  modport sink (input update, input size, input offset, input ext, input we);

endinterface

`default_nettype wire

// File: hdl/lsu_load_align.sv
// writeback control register, load data alignment and extension, held result

`default_nettype none

module lsu_load_align (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           data_rvalid_i,
  input  wire logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_i,
  output logic [lsu_mem_pkg::DATA_W-1:0]      data_rdata_ex_o,
  lsu_wb_if.sink                              wb
);

  // control of the oldest outstanding transaction
  logic [lsu_op_pkg::SIZE_W-1:0] size_q;
  logic [lsu_op_pkg::OFS_W-1:0]  ofs_q;
  logic [lsu_op_pkg::EXT_W-1:0]  ext_q;
  logic                          we_q;

  lsu_mem_pkg::data_word_u       rdata;      // response word, two views
  logic [lsu_op_pkg::OFS_W-1:0]  ofs_hi;     // lane of the upper half byte
  logic [7:0]                    rd_byte;
  logic [15:0]                   rd_half;
  logic                          fill_b;     // upper fill for bytes
  logic                          fill_h;     // upper fill for halves
  logic [lsu_mem_pkg::DATA_W-1:0] result;
  logic [lsu_mem_pkg::DATA_W-1:0] result_q;  // last load result

  ////////////////////
  // control capture
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q <= lsu_op_pkg::SIZE_WORD;
      ofs_q  <= '0;
      ext_q  <= lsu_op_pkg::EXT_ZERO;
      we_q   <= 1'b0;
    end else if (wb.update) begin  // EX handed over, response follows later
      size_q <= wb.size;
      ofs_q  <= wb.offset;
      ext_q  <= wb.ext;
      we_q   <= wb.we;
    end
  end

  ////////////////////
  // lane select
  ////////////////////

  assign rdata.word = data_rdata_i;
  assign ofs_hi     = ofs_q + 1'b1;  // wraps at 3, that case is a misaligned half

  assign rd_byte = rdata.lane[ofs_q];
  assign rd_half = {rdata.lane[ofs_hi], rdata.lane[ofs_q]};

  // zero, ones, or the top bit of the picked data
  always_comb begin
    if (ext_q == lsu_op_pkg::EXT_ZERO) begin
      fill_b = 1'b0;
      fill_h = 1'b0;
    end else if (ext_q == lsu_op_pkg::EXT_ONES) begin
      fill_b = 1'b1;
      fill_h = 1'b1;
    end else begin
      fill_b = rd_byte[7];
      fill_h = rd_half[15];
    end
  end

  always_comb begin
    case (size_q)
      lsu_op_pkg::SIZE_WORD: result = rdata.word;  // no shift, offset ignored
      lsu_op_pkg::SIZE_HALF: result = {{16{fill_h}}, rd_half};
      default:               result = {{24{fill_b}}, rd_byte};
    endcase
  end

  ////////////////////
  // result hold
  ////////////////////

  // stores return nothing useful, keep the previous load value
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !we_q) result_q <= result;
  end

  assign data_rdata_ex_o = data_rvalid_i ? result : result_q;

endmodule

`default_nettype wire

// File: hdl/lsu_mem_pkg.sv
// bus widths, outstanding transaction depth and the response data word union

`default_nettype none

package lsu_mem_pkg;

  ////////////////////
  // bus geometry
  ////////////////////

  localparam int unsigned ADDR_W = 32;  // byte address
  localparam int unsigned DATA_W = 32;  // one bus word
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte lane

  ////////////////////
  // outstanding transactions
  ////////////////////

  localparam int unsigned CNT_W = 2;  // counter must hold 0..DEPTH

  // max number of granted but unanswered transactions
  localparam logic [CNT_W-1:0] DEPTH = 2'd2;

  ////////////////////
  // response word
  ////////////////////

  // the read word is used whole for word loads and per lane for byte/half loads
  typedef union packed {
    logic [DATA_W-1:0]     word;  // full word view
    logic [BE_W-1:0][7:0]  lane;  // lane[0] is bits 7:0
  } data_word_u;

endpackage

`default_nettype wire

// File: hdl/lsu_op_pkg.sv
// access size codes, extension mode codes and byte offset width

`default_nettype none

package lsu_op_pkg;

  ////////////////////
  // access size
  ////////////////////

  localparam int unsigned SIZE_W = 2;

  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd2;  // code 3 is a byte as well

  ////////////////////
  // load extension
  ////////////////////

  localparam int unsigned EXT_W = 2;

  localparam logic [EXT_W-1:0] EXT_ZERO = 2'd0;  // zero fill
  localparam logic [EXT_W-1:0] EXT_ONES = 2'd2;  // one fill
  // codes 1 and 3 sign extend

  // byte offset inside a bus word
  localparam int unsigned OFS_W = 2;

endpackage

`default_nettype wire

// File: hdl/lsu_store_align.sv
// address generation, byte enables, store data rotation and misalignment flag

`default_nettype none

module lsu_store_align (
  input  wire logic [lsu_mem_pkg::ADDR_W-1:0] operand_a_i,
  input  wire logic [lsu_mem_pkg::ADDR_W-1:0] operand_b_i,
  input  wire logic                           addr_useincr_i,  // a + b instead of a
  input  wire logic                           data_we_i,
  input  wire logic [lsu_op_pkg::SIZE_W-1:0]  data_type_i,
  input  wire logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_i,    // store value, byte 0 in lane 0
  input  wire logic                           data_req_i,
  output logic                                misaligned_o,
  lsu_store_if.producer                       st,
  lsu_wb_if.offset_src                        wb
);

  logic [lsu_mem_pkg::ADDR_W-1:0] addr;
  logic [lsu_op_pkg::OFS_W-1:0]   ofs;  // byte offset in the word

  ////////////////////
  // address
  ////////////////////

  assign addr = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign ofs  = addr[lsu_op_pkg::OFS_W-1:0];

  assign st.addr   = addr;  // not word aligned, bus sees the byte address
  assign st.we     = data_we_i;
  assign wb.offset = ofs;    // WB needs it to pick the lanes back out

  ////////////////////
  // byte enables
  ////////////////////

  // only the first phase of a crossing access is ever issued
  always_comb begin
    case (data_type_i)
      lsu_op_pkg::SIZE_WORD: begin
        case (ofs)
          2'd0:    st.be = 4'b1111;
          2'd1:    st.be = 4'b1110;  // upper three lanes, rest lost
          2'd2:    st.be = 4'b1100;
          default: st.be = 4'b1000;
        endcase
      end
      lsu_op_pkg::SIZE_HALF: begin
        case (ofs)
          2'd0:    st.be = 4'b0011;
          2'd1:    st.be = 4'b0110;
          2'd2:    st.be = 4'b1100;
          default: st.be = 4'b1000;  // low byte only
        endcase
      end
      default: st.be = 4'b0001 << ofs;  // SIZE_BYTE and code 3
    endcase
  end

  ////////////////////
  // store data
  ////////////////////

  // rotate left by the offset so byte 0 sits in the addressed lane
  always_comb begin
    case (ofs)
      2'd0:    st.wdata = data_wdata_i;
      2'd1:    st.wdata = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2:    st.wdata = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: st.wdata = {data_wdata_i[7:0], data_wdata_i[31:8]};
    endcase
  end

  // word off the word grid, or a half that spills past lane 3
  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_i) begin
      if (data_type_i == lsu_op_pkg::SIZE_WORD) misaligned_o = (ofs != 2'd0);
      else if (data_type_i == lsu_op_pkg::SIZE_HALF) misaligned_o = (ofs == 2'd3);
    end
  end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
// load/store unit top level, store align, bus controller and load align

`default_nettype none

module lsu_top (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  // data bus
  output logic                                data_req_o,
  input  wire logic                           data_gnt_i,
  input  wire logic                           data_rvalid_i,
  output logic [lsu_mem_pkg::ADDR_W-1:0]      data_addr_o,
  output logic                                data_we_o,
  output logic [lsu_mem_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_mem_pkg::DATA_W-1:0]      data_wdata_o,
  input  wire logic [lsu_mem_pkg::DATA_W-1:0] data_rdata_i,
  // execute stage
  input  wire logic                           data_we_ex_i,
  input  wire logic [lsu_op_pkg::SIZE_W-1:0]  data_type_ex_i,      // word/half/byte
  input  wire logic [lsu_mem_pkg::DATA_W-1:0] data_wdata_ex_i,
  input  wire logic [lsu_op_pkg::EXT_W-1:0]   data_sign_ext_ex_i,  // load fill mode
  output logic [lsu_mem_pkg::DATA_W-1:0]      data_rdata_ex_o,
  input  wire logic                           data_req_ex_i,
  input  wire logic [lsu_mem_pkg::ADDR_W-1:0] operand_a_ex_i,
  input  wire logic [lsu_mem_pkg::ADDR_W-1:0] operand_b_ex_i,
  input  wire logic                           addr_useincr_ex_i,
  output logic                                data_misaligned_o,
  // pipeline control
  output logic                                lsu_ready_ex_o,
  output logic                                lsu_ready_wb_o,
  output logic                                busy_o
);

  lsu_store_if st_if ();  // EX request towards the bus
  lsu_wb_if    wb_if ();  // control towards WB

  // request attributes the WB side keeps for alignment
  assign wb_if.size = data_type_ex_i;
  assign wb_if.ext  = data_sign_ext_ex_i;
  assign wb_if.we   = data_we_ex_i;

  lsu_store_align u_store_align (
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .data_we_i      (data_we_ex_i),
    .data_type_i    (data_type_ex_i),
    .data_wdata_i   (data_wdata_ex_i),
    .data_req_i     (data_req_ex_i),
    .misaligned_o   (data_misaligned_o),
    .st             (st_if.producer),
    .wb             (wb_if.offset_src)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .st             (st_if.consumer),
    .wb             (wb_if.update_src)
  );

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o),
    .wb              (wb_if.sink)
  );

endmodule

`default_nettype wire

// File: test/lsu_checker.sv
// checker with reference model, shadow memory, result compare and per-test report

`default_nettype none

module lsu_checker (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        data_req_ex_i,
  input wire logic        data_we_ex_i,
  input wire logic [1:0]  data_type_ex_i,
  input wire logic [1:0]  data_sign_ext_ex_i,
  input wire logic [31:0] data_wdata_ex_i,
  input wire logic [31:0] operand_a_ex_i,
  input wire logic [31:0] operand_b_ex_i,
  input wire logic        addr_useincr_ex_i,
  input wire logic        data_req_o,
  input wire logic        data_gnt_i,
  input wire logic        data_rvalid_i,
  input wire logic [31:0] data_addr_o,
  input wire logic        data_we_o,
  input wire logic [3:0]  data_be_o,
  input wire logic [31:0] data_wdata_o,
  input wire logic [31:0] data_rdata_ex_o,
  input wire logic        data_misaligned_o,
  input wire logic        lsu_ready_ex_o,
  input wire logic        lsu_ready_wb_o,
  input wire logic        busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int          checks, errors, test_errs, test_no;
  int          outstanding;   // granted on the bus, not yet answered
  logic [31:0] shadow [64];   // what memory should hold
  logic [31:0] exp_q[$];      // expected load values, in order
  logic        is_load_q[$];
  logic [31:0] last_load;
  logic        have_load;

  ////////////////////
  // reference rules
  ////////////////////

  function automatic logic [3:0] lanes_for(input logic [1:0] size, input logic [1:0] ofs);
    if (size == lsu_op_pkg::SIZE_WORD) return 4'b1111 << ofs;  // first phase only
    if (size == lsu_op_pkg::SIZE_HALF) return (ofs == 2'd3) ? 4'b1000 : 4'b0011 << ofs;
    return 4'b0001 << ofs;
  endfunction

  function automatic logic [31:0] rotate_left(input logic [31:0] w, input logic [1:0] ofs);
    return (w << {ofs, 3'b000}) | (w >> (6'd32 - {ofs, 3'b000}));
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] w, input logic [1:0] size,
                                           input logic [1:0] ofs, input logic [1:0] ext);
    logic [31:0] sh;
    logic        fill;
    sh = w >> {ofs, 3'b000};
    if (size == lsu_op_pkg::SIZE_WORD) return w;
    fill = (size == lsu_op_pkg::SIZE_HALF) ? sh[15] : sh[7];  // sign bit
    if (ext == lsu_op_pkg::EXT_ZERO) fill = 1'b0;
    else if (ext == lsu_op_pkg::EXT_ONES) fill = 1'b1;
    if (size == lsu_op_pkg::SIZE_HALF) return {{16{fill}}, sh[15:0]};
    return {{24{fill}}, sh[7:0]};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic end_test(input string name);
    test_no++;
    if (test_errs == 0) $display("test %0d %s: pass", test_no, name);
    else $display("test %0d %s: fail, %0d errors", test_no, name, test_errs);
    test_errs = 0;
  endtask

  ////////////////////
  // per-cycle sampling
  ////////////////////

  task automatic sample();
    logic [31:0] addr;
    logic [1:0]  ofs;
    logic [3:0]  be;
    logic [31:0] wr;
    logic        granted;
    logic        wb_free;
    granted = data_gnt_i || (outstanding == lsu_mem_pkg::DEPTH);  // held one already on bus
    wb_free = (outstanding == 0) || data_rvalid_i;  // WB empty or its response is here
    compare("busy_o", {31'd0, (exp_q.size() != 0) || data_req_ex_i}, {31'd0, busy_o});
    compare("lsu_ready_wb_o", {31'd0, wb_free}, {31'd0, lsu_ready_wb_o});
    compare("data_req_o", {31'd0, data_req_ex_i && (outstanding < lsu_mem_pkg::DEPTH)},
            {31'd0, data_req_o});
    compare("lsu_ready_ex_o", {31'd0, !data_req_ex_i || (granted && wb_free)},
            {31'd0, lsu_ready_ex_o});
    if (data_rvalid_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        test_errs++;
        $display("response arrived with no transaction outstanding at %0t", $time);
      end else if (is_load_q.pop_front()) begin
        last_load = exp_q.pop_front();
        have_load = 1'b1;
        compare("data_rdata_ex_o", last_load, data_rdata_ex_o);
      end else begin
        void'(exp_q.pop_front());
      end
    end else if (have_load) begin
      compare("data_rdata_ex_o", last_load, data_rdata_ex_o);  // held value
    end
    if (data_req_ex_i) begin
      addr = addr_useincr_ex_i ? operand_a_ex_i + operand_b_ex_i : operand_a_ex_i;
      ofs  = addr[1:0];
      be   = lanes_for(data_type_ex_i, ofs);
      wr   = rotate_left(data_wdata_ex_i, ofs);
      compare("data_addr_o", addr, data_addr_o);
      compare("data_we_o", {31'd0, data_we_ex_i}, {31'd0, data_we_o});
      compare("data_be_o", {28'd0, be}, {28'd0, data_be_o});
      if (data_we_ex_i) compare("data_wdata_o", wr, data_wdata_o);
      compare("data_misaligned_o",
              {31'd0, (data_type_ex_i == lsu_op_pkg::SIZE_WORD && ofs != 2'd0) ||
                      (data_type_ex_i == lsu_op_pkg::SIZE_HALF && ofs == 2'd3)},
              {31'd0, data_misaligned_o});
      if (lsu_ready_ex_o) begin  // accepted at the coming edge
        if (data_we_ex_i) begin
          for (int l = 0; l < 4; l++)
            if (be[l]) shadow[addr[7:2]][8*l +: 8] = wr[8*l +: 8];
          exp_q.push_back('0);
          is_load_q.push_back(1'b0);
        end else begin
          exp_q.push_back(load_ref(shadow[addr[7:2]], data_type_ex_i, ofs,
                                   data_sign_ext_ex_i));
          is_load_q.push_back(1'b1);
        end
      end
    end
    // bus handshakes seen at the coming edge
    if (data_req_o && data_gnt_i) outstanding++;
    if (data_rvalid_i) outstanding--;
  endtask

  initial begin
    checks = 0;
    errors = 0;
    test_errs = 0;
    test_no = 0;
    outstanding = 0;
    have_load = 1'b0;
    last_load = '0;
    for (int i = 0; i < 64; i++) shadow[i] = 32'h0101_0101 * i + 32'h00c0_ffee;
    forever begin
      @(negedge clk);
      #8;  // inputs and outputs settled, edge not yet reached
      if (rst_n) sample();
    end
  end

endmodule

`default_nettype wire

// File: test/lsu_properties.sv
// concurrent assertions on the bus controller, bound into lsu_bus_ctrl

`default_nettype none

module lsu_properties (
  input wire logic                          clk,
  input wire logic                          rst_n,
  input wire logic [lsu_mem_pkg::CNT_W-1:0] cnt_q,
  input wire logic                          data_req_o,
  input wire logic                          data_gnt_i,
  input wire logic                          data_rvalid_i,
  input wire logic [31:0]                   data_addr_o,
  input wire logic                          data_we_o,
  input wire logic [3:0]                    data_be_o
);
  timeunit 1ns;
  timeprecision 1ps;

  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_mem_pkg::DEPTH) else $error("outstanding count above depth");

  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> cnt_q != '0) else $error("response with nothing outstanding");

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({data_addr_o, data_we_o, data_be_o}))
    else $error("unknown request payload");

  // request and address hold until granted
  a_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o))
    else $error("request dropped or moved before grant");

endmodule

bind lsu_bus_ctrl lsu_properties u_props (
  .clk (clk), .rst_n (rst_n), .cnt_q (cnt_q), .data_req_o (data_req_o),
  .data_gnt_i (data_gnt_i), .data_rvalid_i (data_rvalid_i), .data_addr_o (data_addr_o),
  .data_we_o (data_we_o), .data_be_o (data_be_o)
);

`default_nettype wire

// File: test/lsu_tb.sv
// testbench top with clock, reset, stimulus, bus memory model and watchdog

`default_nettype none

module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS    = 20;
  localparam int N_TRANS   = 76;  // requests issued over all tests
  localparam int MEM_WORDS = 64;

  logic        clk;
  logic        rst_n;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i, data_rdata_ex_o;
  logic [3:0]  data_be_o;
  logic        data_we_ex_i, data_req_ex_i, addr_useincr_ex_i;
  logic [1:0]  data_type_ex_i, data_sign_ext_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;

  logic        hold_gnt;              // memory refuses grants while set
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rdat_q[$];             // responses in flight, in order
  int          due_q[$];              // cycle each response is due
  int          cyc;
  int          gnt_wait;
  logic        wait_armed;
  logic [31:0] wd;

  lsu_top uut (.*);

  lsu_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  //////////////////////
  // memory model
  //////////////////////

  // runs just after the falling edge so the request is settled
  always @(negedge clk) begin
    #1;
    cyc++;
    data_rvalid_i = 1'b0;
    data_gnt_i    = 1'b0;
    if (rst_n) begin
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rdat_q.pop_front();
        void'(due_q.pop_front());
      end
      if (data_req_o && !hold_gnt) begin
        if (!wait_armed) begin
          gnt_wait   = $urandom_range(2, 0);  // grant delay 0..2
          wait_armed = 1'b1;
        end
        if (gnt_wait > 0) gnt_wait--;
        else begin
          data_gnt_i = 1'b1;
          wait_armed = 1'b0;
          for (int l = 0; l < 4; l++)
            if (data_we_o && data_be_o[l])
              mem[data_addr_o[7:2]][8*l +: 8] = data_wdata_o[8*l +: 8];
          rdat_q.push_back(mem[data_addr_o[7:2]]);
          due_q.push_back(cyc + $urandom_range(3, 1));
        end
      end
    end
  end

  //////////////////////
  // stimulus helpers
  //////////////////////

  // one request, held until the execute side is accepted
  task automatic issue(input logic we, input logic [1:0] size, input logic [1:0] ext,
                       input logic [31:0] addr, input logic [31:0] wdata, input logic incr);
    logic        acc;
    logic [31:0] a;
    a                  = $urandom;
    addr_useincr_ex_i  = incr;
    operand_a_ex_i     = incr ? a : addr;
    operand_b_ex_i     = incr ? addr - a : a;  // b is ignored without incr
    data_req_ex_i      = 1'b1;
    data_we_ex_i       = we;
    data_type_ex_i     = size;
    data_sign_ext_ex_i = ext;
    data_wdata_ex_i    = wdata;
    acc = 1'b0;
    while (!acc) begin
      #8;
      acc = lsu_ready_ex_o;  // sampled just before the rising edge
      @(negedge clk);
    end
    data_req_ex_i = 1'b0;
  endtask

  // wait until all responses are back
  task automatic drain();
    logic b;
    do begin
      #8;
      b = busy_o;
      @(negedge clk);
    end while (b);
  endtask

  function automatic logic rnd_bit();
    return 1'($urandom_range(1, 0));
  endfunction

  //////////////////////
  // test sequence
  //////////////////////

  initial begin
    void'($urandom(70068));
    rst_n = 1'b0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = lsu_op_pkg::SIZE_WORD;
    data_sign_ext_ex_i = lsu_op_pkg::EXT_ZERO;
    data_wdata_ex_i = '0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    hold_gnt = 1'b0;
    cyc = 0;
    gnt_wait = 0;
    wait_armed = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h0101_0101 * i + 32'h00c0_ffee;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 8; i++) issue(1'b1, lsu_op_pkg::SIZE_WORD, 2'd0, 4 * i, $urandom, 1'b1);
    for (int i = 0; i < 8; i++) issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 4 * i, 0, 1'b1);
    drain();
    chk.end_test("aligned word store and load");

    for (int e = 0; e < 4; e++) begin
      for (int o = 0; o < 4; o++) issue(1'b0, lsu_op_pkg::SIZE_BYTE, 2'(e), 20 + o, 0, rnd_bit());
      for (int o = 0; o < 3; o++) issue(1'b0, lsu_op_pkg::SIZE_HALF, 2'(e), 20 + o, 0, rnd_bit());
    end
    drain();
    chk.end_test("byte and half loads");

    for (int o = 0; o < 4; o++) begin
      issue(1'b1, lsu_op_pkg::SIZE_BYTE, 2'd0, 36 + o, $urandom, rnd_bit());
      issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 36, 0, rnd_bit());
    end
    for (int o = 0; o < 3; o++) begin
      issue(1'b1, lsu_op_pkg::SIZE_HALF, 2'd0, 40 + o, $urandom, rnd_bit());
      issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 40, 0, rnd_bit());
    end
    drain();
    chk.end_test("byte and half stores");

    for (int o = 1; o < 4; o++) begin
      issue(1'b1, lsu_op_pkg::SIZE_WORD, 2'd0, 48 + o, $urandom, rnd_bit());
      issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 48, 0, rnd_bit());
    end
    issue(1'b1, lsu_op_pkg::SIZE_HALF, 2'd0, 55, $urandom, rnd_bit());
    issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 52, 0, rnd_bit());
    drain();
    chk.end_test("misaligned stores");

    wd = $urandom;
    hold_gnt = 1'b1;
    fork
      issue(1'b1, lsu_op_pkg::SIZE_WORD, 2'd0, 60, wd, rnd_bit());
      begin
        repeat (6) @(negedge clk);
        hold_gnt = 1'b0;
      end
    join
    for (int i = 0; i < 6; i++) issue(1'b0, lsu_op_pkg::SIZE_WORD, 2'd0, 4 * i, 0, rnd_bit());
    drain();
    repeat (4) @(negedge clk);
    chk.end_test("grant back-pressure and back-to-back");

    for (int i = 0; i < 3; i++) begin
      issue(1'b0, lsu_op_pkg::SIZE_BYTE, 2'd1, 20 + i, 0, rnd_bit());
      drain();
      repeat (4) @(negedge clk);  // output must hold through the gap
    end
    chk.end_test("load result hold");

    $display("checks %0d, errors %0d", chk.checks, chk.errors);
    if (chk.errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog, 8 cycles per transaction plus slack
  initial begin
    #(CLK_NS * (N_TRANS * 8 + 100));
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/lsu_mem_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_ifs.sv
hdl/lsu_store_align.sv
hdl/lsu_bus_ctrl.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
test/lsu_properties.sv
test/lsu_checker.sv
test/lsu_tb.sv
